// File: cnn_layer_accel_awp.f
design/awp_pkg.sv
design/awp_sync_fifo.sv
design/awp_dispatch.sv
design/awp_cfg_regs.sv
design/awp_quad.sv
design/cnn_layer_accel_awp.sv
verif/awp_properties.sv
verif/tb_awp.sv

// File: Makefile
# Verilator simulation of the AWP transaction path

VERILATOR ?= verilator
TOP       ?= tb_awp
FILELIST  ?= cnn_layer_accel_awp.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SOURCES   := $(wildcard design/*.sv verif/*.sv)
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator and run; fails unless the pass message appears"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tb_awp.sv
`default_nettype none

module tb_awp import awp_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int INGRESS_DEPTH = 8;
    localparam int RESULT_DEPTH  = 8;

    // Transactions per test phase
    localparam int N_ZERO_PIX = 4;
    localparam int N_DROP     = 4;
    localparam int N_RAND_PIX = 24;
    localparam int N_MIX_GRP  = 3;
    localparam int N_MIX_PIX  = 6;
    localparam int N_BP_PIX   = 32;
    localparam int N_TOTAL    = N_ZERO_PIX + N_DROP + 1 + N_RAND_PIX
                              + N_MIX_GRP * (N_MIX_PIX + 1) + N_BP_PIX;
    localparam int WATCHDOG_CYCLES = 20 * N_TOTAL + 2000;

    logic                   clk_FAS = 1'b0;
    logic                   rst;
    logic                   trans_in_fifo_din_vld;
    logic                   trans_in_fifo_din_rdy;
    logic [TRANS_WIDTH-1:0] trans_in_fifo_din;
    logic                   trans_eg_fifo_dout_vld;
    logic                   trans_eg_fifo_dout_rdy;
    logic [TRANS_WIDTH-1:0] trans_eg_fifo_dout;

    integer                 seed;
    // Weights as the DUT should hold them for the next pixel word
    logic [PIXEL_WIDTH-1:0] model_w [NUM_QUADS];
    awp_payload_u           exp_q [$];
    int                     value_errors = 0;
    int                     other_errors = 0;
    int                     results_seen = 0;
    logic                   bp_phase = 1'b0;
    logic                   bp_sends_done = 1'b0;
    logic                   saw_in_full = 1'b0;

    cnn_layer_accel_awp #(
        .INGRESS_DEPTH (INGRESS_DEPTH),
        .RESULT_DEPTH  (RESULT_DEPTH)
    ) dut0 (
        .clk_FAS                (clk_FAS),
        .rst                    (rst),
        .trans_in_fifo_din_vld  (trans_in_fifo_din_vld),
        .trans_in_fifo_din_rdy  (trans_in_fifo_din_rdy),
        .trans_in_fifo_din      (trans_in_fifo_din),
        .trans_eg_fifo_dout_vld (trans_eg_fifo_dout_vld),
        .trans_eg_fifo_dout_rdy (trans_eg_fifo_dout_rdy),
        .trans_eg_fifo_dout     (trans_eg_fifo_dout)
    );

    // 8 ns period
    always #4 clk_FAS = !clk_FAS;

    //////////////////////////////////////////////////////////////////////
    // Reference model and stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // Dot product of one pixel word with the model weights
    function automatic logic [SUM_WIDTH-1:0] awp_dot(input awp_payload_u pyld);
        int acc;
        acc = 0;
        for (int q = 0; q < NUM_QUADS; q++) begin
            acc += int'(pyld.pixels[q]) * int'(model_w[q]);
        end
        return SUM_WIDTH'(acc);
    endfunction

    function automatic awp_payload_u rand_payload();
        logic [31:0] r;
        r = $random(seed);
        return awp_payload_u'(r);
    endfunction

    // Called just after a rising edge, returns at the accepting edge
    task automatic send_word(input trans_type_e ttype, input awp_payload_u pyld);
        logic [31:0] r;
        r = $random(seed);
        // Upper metadata bits are noise, the DUT must ignore them
        trans_in_fifo_din_vld <= 1'b1;
        trans_in_fifo_din     <= {r[META_WIDTH-1:TYPE_WIDTH], ttype, pyld};
        @(posedge clk_FAS);
        while (!trans_in_fifo_din_rdy) begin
            @(posedge clk_FAS);
        end
        if (ttype == TRANS_PIXEL) begin
            exp_q.push_back(awp_payload_u'(PYLD_WIDTH'(awp_dot(pyld))));
        end else if (ttype == TRANS_CFG) begin
            // Later pixels see the new set, earlier ones are already queued
            for (int q = 0; q < NUM_QUADS; q++) begin
                model_w[q] = pyld.weights[q];
            end
        end
    endtask

    task automatic randomize_egress_rdy(input int cycles);
        logic [31:0] r;
        repeat (cycles) begin
            @(posedge clk_FAS);
            r = $random(seed);
            trans_eg_fifo_dout_rdy <= r[0];
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic check_result(input logic [META_WIDTH-TYPE_WIDTH-1:0] got_meta_hi,
                                input trans_type_e got_type, input awp_payload_u got,
                                input awp_payload_u exp);
        results_seen++;
        if (got_meta_hi != '0) begin
            value_errors++;
            $display("** Error at %0t ns: result %0d upper metadata 0x%h, expected zero",
                     $time, results_seen, got_meta_hi);
        end
        if (got_type != TRANS_RESULT) begin
            value_errors++;
            $display("** Error at %0t ns: result %0d has type %0d, expected %0d",
                     $time, results_seen, got_type, TRANS_RESULT);
        end
        if (got != exp) begin
            value_errors++;
            $display("** Error at %0t ns: result %0d payload 0x%h, expected 0x%h",
                     $time, results_seen, got, exp);
        end
    endtask

    task automatic check_empty(input int unsigned n, input string what);
        if (n != 0) begin
            other_errors++;
            $display("At %0t ns: %0d %s", $time, n, what);
        end
    endtask

    // Egress handshakes, sampled at the edge that pops the word
    initial begin : compare_egress
        awp_payload_u exp_pyld;
        forever begin
            @(posedge clk_FAS);
            if (!rst && trans_eg_fifo_dout_vld && trans_eg_fifo_dout_rdy) begin
                if (exp_q.size() == 0) begin
                    check_empty(1, "egress word arrived with no pixel transaction pending");
                end else begin
                    exp_pyld = exp_q.pop_front();
                    check_result(trans_eg_fifo_dout[TRANS_WIDTH-1 -: META_WIDTH-TYPE_WIDTH],
                                 trans_type_e'(trans_eg_fifo_dout[PYLD_WIDTH +: TYPE_WIDTH]),
                                 awp_payload_u'(trans_eg_fifo_dout[PYLD_WIDTH-1:0]), exp_pyld);
                end
            end
        end
    end

    // Ingress back-pressure seen during the stall phase
    initial begin : watch_ingress_full
        forever begin
            @(posedge clk_FAS);
            if (bp_phase && !trans_in_fifo_din_rdy) begin
                saw_in_full = 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_FAS);
        $display("Watchdog expired after %0d cycles with %0d results pending",
                 WATCHDOG_CYCLES, exp_q.size());
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin : run_tests
        seed                   = 32'hcea9;
        rst                    = 1'b1;
        trans_in_fifo_din_vld  = 1'b0;
        trans_in_fifo_din      = '0;
        trans_eg_fifo_dout_rdy = 1'b1;
        for (int q = 0; q < NUM_QUADS; q++) begin
            model_w[q] = '0;
        end
        repeat (16) @(posedge clk_FAS);
        rst <= 1'b0;
        @(posedge clk_FAS);
        if (!trans_in_fifo_din_rdy || trans_eg_fifo_dout_vld) begin
            other_errors++;
            $display("At %0t ns: ingress not ready or egress valid after reset", $time);
        end

        // Reset weights are zero
        repeat (N_ZERO_PIX) send_word(TRANS_PIXEL, rand_payload());
        // Dropped types give no egress word
        for (int i = 0; i < N_DROP; i++) begin
            send_word((i % 2 == 0) ? TRANS_NONE : TRANS_RESULT, rand_payload());
        end
        send_word(TRANS_CFG, rand_payload());
        repeat (N_RAND_PIX) send_word(TRANS_PIXEL, rand_payload());
        // Config between pixel runs, applied only after the chain drains
        repeat (N_MIX_GRP) begin
            send_word(TRANS_CFG, rand_payload());
            repeat (N_MIX_PIX) send_word(TRANS_PIXEL, rand_payload());
        end

        // Egress stall, short release, second stall, then random rdy
        bp_phase               <= 1'b1;
        trans_eg_fifo_dout_rdy <= 1'b0;
        fork
            begin
                repeat (N_BP_PIX) send_word(TRANS_PIXEL, rand_payload());
                trans_in_fifo_din_vld <= 1'b0;
                bp_sends_done = 1'b1;
            end
            begin
                repeat (120) @(posedge clk_FAS);
                randomize_egress_rdy(40);
                trans_eg_fifo_dout_rdy <= 1'b0;
                repeat (120) @(posedge clk_FAS);
                while (!bp_sends_done || exp_q.size() != 0) begin
                    randomize_egress_rdy(1);
                end
            end
        join
        trans_in_fifo_din_vld  <= 1'b0;
        trans_eg_fifo_dout_rdy <= 1'b1;
        bp_phase               <= 1'b0;

        // Quiet period to catch stray egress words
        repeat (4 * NUM_QUADS + 8) @(posedge clk_FAS);
        check_empty(exp_q.size(), "expected results never reached egress");
        if (!saw_in_full) begin
            other_errors++;
            $display("Ingress ready never fell while egress was stalled");
        end
        $display("Results checked %0d, value errors %0d, other errors %0d, assert failures %0d",
                 results_seen, value_errors, other_errors, dut0.u_awp_properties.failures);
        if (value_errors == 0 && other_errors == 0 && dut0.u_awp_properties.failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/awp_properties.sv
`default_nettype none

module awp_properties import awp_pkg::*; (
    input wire logic                   clk_FAS,
    input wire logic                   rst,
    input wire logic                   trans_eg_fifo_dout_vld,
    input wire logic                   trans_eg_fifo_dout_rdy,
    input wire logic [TRANS_WIDTH-1:0] trans_eg_fifo_dout
);

    timeunit 1ns;
    timeprecision 100ps;

    // Assertion failures so far
    int unsigned failures = 0;

    //////////////////////////////////////////////////////////////////////
    // Egress word format and handshake
    //////////////////////////////////////////////////////////////////////

    // Every egress word is a result
    a_eg_type: assert property (@(posedge clk_FAS) disable iff (rst)
        trans_eg_fifo_dout_vld |->
            trans_eg_fifo_dout[PYLD_WIDTH +: TYPE_WIDTH] == TRANS_RESULT)
        else begin
            $error("egress word without result type");
            failures++;
        end

    // Word held steady under back-pressure
    a_eg_hold: assert property (@(posedge clk_FAS) disable iff (rst)
        (trans_eg_fifo_dout_vld && !trans_eg_fifo_dout_rdy) |=>
            (trans_eg_fifo_dout_vld && $stable(trans_eg_fifo_dout)))
        else begin
            $error("egress word changed or dropped while stalled");
            failures++;
        end

    // Sum is zero-extended into the payload
    a_eg_zext: assert property (@(posedge clk_FAS) disable iff (rst)
        trans_eg_fifo_dout_vld |->
            trans_eg_fifo_dout[PYLD_WIDTH-1:SUM_WIDTH] == '0)
        else begin
            $error("egress payload bits above the sum are not zero");
            failures++;
        end

endmodule

bind cnn_layer_accel_awp awp_properties u_awp_properties (
    .clk_FAS                (clk_FAS),
    .rst                    (rst),
    .trans_eg_fifo_dout_vld (trans_eg_fifo_dout_vld),
    .trans_eg_fifo_dout_rdy (trans_eg_fifo_dout_rdy),
    .trans_eg_fifo_dout     (trans_eg_fifo_dout)
);

`default_nettype wire

// File: design/cnn_layer_accel_awp.sv
`default_nettype none

module cnn_layer_accel_awp import awp_pkg::*; #(
    parameter int INGRESS_DEPTH = 8,
    parameter int RESULT_DEPTH  = 8
) (
    input  wire logic                   clk_FAS,
    input  wire logic                   rst,
    input  wire logic                   trans_in_fifo_din_vld,
    output logic                        trans_in_fifo_din_rdy,
    input  wire logic [TRANS_WIDTH-1:0] trans_in_fifo_din,
    output logic                        trans_eg_fifo_dout_vld,
    input  wire logic                   trans_eg_fifo_dout_rdy,
    output logic      [TRANS_WIDTH-1:0] trans_eg_fifo_dout
);

    localparam int RES_CNT_W = $clog2(RESULT_DEPTH + 1);

    // Ingress side
    logic                   in_wren;
    logic                   in_full;
    logic                   in_empty;
    logic                   in_rden;
    logic [TRANS_WIDTH-1:0] in_dout;

    // Dispatcher outputs
    logic         cfg_wr;
    awp_payload_u cfg_weights;
    logic         pix_issue;
    awp_payload_u pix_lanes;

    logic [PIXEL_WIDTH-1:0] weights [NUM_QUADS];

    // Entry 0 feeds quad 0, entry NUM_QUADS leaves the last quad
    logic                 casc_valid [NUM_QUADS+1];
    logic [SUM_WIDTH-1:0] casc_sum   [NUM_QUADS+1];

    // Result side
    logic                 result_wr;
    logic                 result_rden;
    logic                 result_empty;
    logic [SUM_WIDTH-1:0] result_dout;
    logic [RES_CNT_W-1:0] result_count;

    //////////////////////////////////////////////////////////////////////
    // Ingress FIFO
    //////////////////////////////////////////////////////////////////////
    assign trans_in_fifo_din_rdy = !in_full;
    assign in_wren = trans_in_fifo_din_vld && trans_in_fifo_din_rdy;

    awp_sync_fifo #(.WIDTH(TRANS_WIDTH), .DEPTH(INGRESS_DEPTH)) u_in_fifo (
        .clk_FAS (clk_FAS),
        .rst     (rst),
        .wren    (in_wren),
        .din     (trans_in_fifo_din),
        .rden    (in_rden),
        .dout    (in_dout),
        .empty   (in_empty),
        .full    (in_full),
        .count   ()
    );

    awp_dispatch #(.RESULT_DEPTH(RESULT_DEPTH)) u_dispatch (
        .clk_FAS      (clk_FAS),
        .rst          (rst),
        .in_empty     (in_empty),
        .in_dout      (in_dout),
        .in_rden      (in_rden),
        .result_count (result_count),
        .result_wr    (result_wr),
        .cfg_wr       (cfg_wr),
        .cfg_weights  (cfg_weights),
        .pix_issue    (pix_issue),
        .pix_lanes    (pix_lanes)
    );

    awp_cfg_regs u_cfg_regs (
        .clk_FAS     (clk_FAS),
        .rst         (rst),
        .cfg_wr      (cfg_wr),
        .cfg_weights (cfg_weights),
        .weights     (weights)
    );

    //////////////////////////////////////////////////////////////////////
    // Quad cascade
    //////////////////////////////////////////////////////////////////////

    // Chain head starts from zero on each issued pixel word
    assign casc_valid[0] = pix_issue;
    assign casc_sum[0]   = '0;

    for (genvar q = 0; q < NUM_QUADS; q++) begin : g_quad
        awp_quad #(.QUAD_INDEX(q)) u_quad (
            .clk_FAS           (clk_FAS),
            .rst               (rst),
            .pixel             (pix_lanes.pixels[q]),
            .weight            (weights[q]),
            .cascade_in_valid  (casc_valid[q]),
            .cascade_in_sum    (casc_sum[q]),
            .cascade_out_valid (casc_valid[q+1]),
            .cascade_out_sum   (casc_sum[q+1])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Result FIFO and egress word
    //////////////////////////////////////////////////////////////////////
    assign result_wr   = casc_valid[NUM_QUADS];
    assign result_rden = trans_eg_fifo_dout_vld && trans_eg_fifo_dout_rdy;

    // Credit check keeps this from ever filling past DEPTH
    awp_sync_fifo #(.WIDTH(SUM_WIDTH), .DEPTH(RESULT_DEPTH)) u_result_fifo (
        .clk_FAS (clk_FAS),
        .rst     (rst),
        .wren    (result_wr),
        .din     (casc_sum[NUM_QUADS]),
        .rden    (result_rden),
        .dout    (result_dout),
        .empty   (result_empty),
        .full    (),
        .count   (result_count)
    );

    assign trans_eg_fifo_dout_vld = !result_empty;
    // Result type in metadata, sum zero-extended in payload
    assign trans_eg_fifo_dout = {{(META_WIDTH-TYPE_WIDTH){1'b0}}, TRANS_RESULT,
                                 {(PYLD_WIDTH-SUM_WIDTH){1'b0}}, result_dout};

endmodule

`default_nettype wire

// File: design/awp_quad.sv
`default_nettype none

module awp_quad import awp_pkg::*; #(
    parameter int QUAD_INDEX = 0
) (
    input  wire logic                   clk_FAS,
    input  wire logic                   rst,
    input  wire logic [PIXEL_WIDTH-1:0] pixel,
    input  wire logic [PIXEL_WIDTH-1:0] weight,
    input  wire logic                   cascade_in_valid,
    input  wire logic [SUM_WIDTH-1:0]   cascade_in_sum,
    output logic                        cascade_out_valid,
    output logic      [SUM_WIDTH-1:0]   cascade_out_sum
);

    logic [PIXEL_WIDTH-1:0]   pixel_skewed;
    logic [2*PIXEL_WIDTH-1:0] product;

    //////////////////////////////////////////////////////////////////////
    // Pixel skew
    //////////////////////////////////////////////////////////////////////

    // Partial sum reaches quad i i cycles after quad 0
    if (QUAD_INDEX == 0) begin : g_no_skew
        assign pixel_skewed = pixel;
    end else begin : g_skew
        logic [PIXEL_WIDTH-1:0] skew_q [QUAD_INDEX];

        always_ff @(posedge clk_FAS) begin
            skew_q[0] <= pixel;
            for (int s = 1; s < QUAD_INDEX; s++) begin
                skew_q[s] <= skew_q[s-1];
            end
        end

        assign pixel_skewed = skew_q[QUAD_INDEX-1];
    end

    //////////////////////////////////////////////////////////////////////
    // Multiply-add stage
    //////////////////////////////////////////////////////////////////////
    assign product = pixel_skewed * weight;

    always_ff @(posedge clk_FAS) begin
        if (rst) begin
            cascade_out_valid <= 1'b0;
        end else begin
            cascade_out_valid <= cascade_in_valid;
        end
    end

    // Sum holds between transactions
    always_ff @(posedge clk_FAS) begin
        if (cascade_in_valid) begin
            cascade_out_sum <= cascade_in_sum + SUM_WIDTH'(product);
        end
    end

endmodule

`default_nettype wire

// File: design/awp_cfg_regs.sv
`default_nettype none

module awp_cfg_regs import awp_pkg::*; (
    input  wire logic                   clk_FAS,
    input  wire logic                   rst,
    input  wire logic                   cfg_wr,
    input  wire awp_payload_u           cfg_weights,
    output logic      [PIXEL_WIDTH-1:0] weights [NUM_QUADS]
);

    //////////////////////////////////////////////////////////////////////
    // Quad weight registers
    //////////////////////////////////////////////////////////////////////

    // Zero weights until the first config arrives
    always_ff @(posedge clk_FAS) begin
        if (rst) begin
            for (int q = 0; q < NUM_QUADS; q++) begin
                weights[q] <= '0;
            end
        end else if (cfg_wr) begin
            // Whole set loads at once
            for (int q = 0; q < NUM_QUADS; q++) begin
                weights[q] <= cfg_weights.weights[q];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/awp_dispatch.sv
`default_nettype none

module awp_dispatch import awp_pkg::*; #(
    parameter int RESULT_DEPTH = 8
) (
    input  wire logic                              clk_FAS,
    input  wire logic                              rst,
    input  wire logic                              in_empty,
    input  wire logic [TRANS_WIDTH-1:0]            in_dout,
    output logic                                   in_rden,
    input  wire logic [$clog2(RESULT_DEPTH+1)-1:0] result_count,
    input  wire logic                              result_wr,
    output logic                                   cfg_wr,
    output awp_payload_u                           cfg_weights,
    output logic                                   pix_issue,
    output awp_payload_u                           pix_lanes
);

    localparam int CNT_W = $clog2(RESULT_DEPTH + 1);

    logic [META_WIDTH-1:0] head_meta;
    trans_type_e           head_type;
    awp_payload_u          head_pyld;
    logic [CNT_W-1:0]      in_flight;
    logic [CNT_W:0]        credit_used;
    logic                  cfg_ok;
    logic                  pix_ok;
    logic                  pop_cfg;
    logic                  pop_pix;

    //////////////////////////////////////////////////////////////////////
    // Head decode
    //////////////////////////////////////////////////////////////////////
    assign head_meta = in_dout[TRANS_WIDTH-1 -: META_WIDTH];
    assign head_type = trans_type_e'(head_meta[TYPE_WIDTH-1:0]);
    assign head_pyld = awp_payload_u'(in_dout[PYLD_WIDTH-1:0]);

    // Results stored plus results still in the chain
    assign credit_used = {1'b0, result_count} + {1'b0, in_flight};

    // Config waits for an empty chain
    assign cfg_ok = (in_flight == '0);
    // Pixel needs a guaranteed slot in the result FIFO
    assign pix_ok = (credit_used < (CNT_W + 1)'(RESULT_DEPTH));

    assign pop_cfg = !in_empty && (head_type == TRANS_CFG) && cfg_ok;
    assign pop_pix = !in_empty && (head_type == TRANS_PIXEL) && pix_ok;

    // NONE and RESULT heads are popped and dropped
    always_comb begin
        in_rden = 1'b0;
        if (!in_empty) begin
            case (head_type)
                TRANS_CFG:   in_rden = cfg_ok;
                TRANS_PIXEL: in_rden = pix_ok;
                default:     in_rden = 1'b1;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Issue strobes and chain occupancy
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_FAS) begin
        if (rst) begin
            cfg_wr    <= 1'b0;
            pix_issue <= 1'b0;
            in_flight <= '0;
        end else begin
            cfg_wr    <= pop_cfg;
            pix_issue <= pop_pix;
            // Counted from the pop edge so a trailing config sees it
            if (pop_pix && !result_wr) begin
                in_flight <= in_flight + 1'b1;
            end else if (result_wr && !pop_pix) begin
                in_flight <= in_flight - 1'b1;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk_FAS) begin
        if (pop_cfg) begin
            cfg_weights.weights <= head_pyld.weights;
        end
        if (pop_pix) begin
            pix_lanes.pixels <= head_pyld.pixels;
        end
    end

endmodule

`default_nettype wire

// File: design/awp_sync_fifo.sv
`default_nettype none

module awp_sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  wire logic                       clk_FAS,
    input  wire logic                       rst,
    input  wire logic                       wren,
    input  wire logic [WIDTH-1:0]           din,
    input  wire logic                       rden,
    output logic      [WIDTH-1:0]           dout,
    output logic                            empty,
    output logic                            full,
    output logic      [$clog2(DEPTH+1)-1:0] count
);

    localparam int CNT_W = $clog2(DEPTH + 1);
    // Keep at least one pointer bit for a single-entry FIFO
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    // Overflow and underflow requests are dropped
    assign do_wr = wren && !full;
    assign do_rd = rden && !empty;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // Fall-through head
    assign dout = mem[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_FAS) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                // Wrap at DEPTH, not at a power of two
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage array
    always_ff @(posedge clk_FAS) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

endmodule

`default_nettype wire

// File: design/awp_pkg.sv
`default_nettype none

package awp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////////////////////////

    // Quads in the cascade
    localparam int NUM_QUADS   = 4;

    // One pixel or one weight
    localparam int PIXEL_WIDTH = 8;

    // Payload carries one lane per quad
    localparam int PYLD_WIDTH  = NUM_QUADS * PIXEL_WIDTH;

    // Metadata sits above the payload
    localparam int META_WIDTH  = 8;
    localparam int TYPE_WIDTH  = 2;
    localparam int TRANS_WIDTH = META_WIDTH + PYLD_WIDTH;

    // Four 8x8 products need 16 + 2 bits
    localparam int SUM_WIDTH   = 18;

    //////////////////////////////////////////////////////////////////////
    // Transaction encoding
    //////////////////////////////////////////////////////////////////////

    // Low two metadata bits, upper bits ignored on ingress
    typedef enum logic [TYPE_WIDTH-1:0] {
        TRANS_NONE   = 2'd0,
        TRANS_CFG    = 2'd1,
        TRANS_PIXEL  = 2'd2,
        // Egress only
        TRANS_RESULT = 2'd3
    } trans_type_e;

    // Lane i of either view belongs to quad i
    typedef logic [NUM_QUADS-1:0][PIXEL_WIDTH-1:0] awp_lanes_t;

    // Same payload word, decoded by transaction type
    typedef union packed {
        // Config word, one weight per quad
        awp_lanes_t weights;
        // Pixel word, one pixel per quad
        awp_lanes_t pixels;
    } awp_payload_u;

endpackage

`default_nettype wire
